//--- common/pu_pkg.sv
`default_nettype none

package pu_pkg;

    localparam int data_width = 16;
    localparam int win_size   = 5;
    localparam int win_elems  = win_size * win_size;

    // 25 products of 32 bits need 5 more bits of headroom.
    localparam int acc_width  = 40;
    localparam int word_width = 21;

    // word kind, sampled together with the stream word.
    localparam logic kind_pixel  = 1'b0;
    localparam logic kind_weight = 1'b1;

    // one stream word, read as a pixel or as a weight depending on the kind.
    typedef union packed {
        struct packed {
            logic [2:0]                       row;
            logic [word_width-data_width-4:0] pad;
            logic signed [data_width-1:0]     pixel;
        } pix;
        struct packed {
            logic [word_width-data_width-1:0] idx;
            logic signed [data_width-1:0]     weight;
        } wgt;
    } stream_word_u;

endpackage

`default_nettype wire

//--- rtl/stream_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module stream_unpack
(
    input  wire                                  clk,
    input  wire                                  nrst,
    input  wire                                  in_valid,
    input  wire                                  in_kind,
    input  wire pu_pkg::stream_word_u            in_word,
    output logic                                 in_ready,
    output logic                                 w_wr,
    output logic [4:0]                           w_idx,
    output logic signed [pu_pkg::data_width-1:0] w_data,
    output logic                                 col_valid,
    input  wire                                  col_ready,
    output logic signed [pu_pkg::data_width-1:0] col_data [pu_pkg::win_size]
);
    import pu_pkg::*;

    logic col_full;
    logic wgt_take;
    logic pix_take;

    // pixel words wait while the finished column is still pending.
    assign in_ready = (in_kind == kind_weight) || !col_full;
    assign wgt_take = in_valid && (in_kind == kind_weight);
    assign pix_take = in_valid && in_ready && (in_kind == kind_pixel);

    assign col_valid = col_full;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            w_wr     <= 1'b0;
            col_full <= 1'b0;
        end
        else
        begin
            w_wr <= wgt_take;
            // the last row completes the column.
            if (pix_take && in_word.pix.row == 3'(win_size - 1))
                col_full <= 1'b1;
            else if (col_ready)
                col_full <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wgt_take)
        begin
            w_idx  <= in_word.wgt.idx;
            w_data <= in_word.wgt.weight;
        end
        if (pix_take && in_word.pix.row < 3'(win_size))
            col_data[in_word.pix.row] <= in_word.pix.pixel;
    end

endmodule

`default_nettype wire

//--- rtl/weight_store.sv
`timescale 1ns/1ps
`default_nettype none

module weight_store
(
    input  wire                                  clk,
    input  wire                                  nrst,
    input  wire                                  w_wr,
    input  wire [4:0]                            w_idx,
    input  wire signed [pu_pkg::data_width-1:0]  w_data,
    output logic signed [pu_pkg::data_width-1:0] weights [pu_pkg::win_elems]
);
    import pu_pkg::*;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < win_elems; i++)
                weights[i] <= '0;
        end
        else if (w_wr && w_idx < 5'(win_elems))
        begin
            weights[w_idx] <= w_data;
        end
    end

endmodule

`default_nettype wire

//--- pu_control/window_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module window_ctrl
#(
    parameter int img_width = 8
)
(
    input  wire                                  clk,
    input  wire                                  nrst,
    input  wire                                  col_valid,
    input  wire signed [pu_pkg::data_width-1:0]  col_data [pu_pkg::win_size],
    output logic                                 col_ready,
    output logic                                 win_valid,
    input  wire                                  win_ready,
    output logic signed [pu_pkg::data_width-1:0] win_data [pu_pkg::win_elems]
);
    import pu_pkg::*;

    localparam int cnt_width = $clog2(img_width);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_shift = 2'd1;
    localparam logic [1:0] st_emit  = 2'd2;

    logic [1:0]                   state;
    logic [cnt_width-1:0]         col_cnt;
    logic signed [data_width-1:0] reuse [win_size-1][win_size];
    logic signed [data_width-1:0] new_col [win_size];

    assign col_ready = (state == st_idle);
    assign win_valid = (state == st_emit);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state   <= st_idle;
            col_cnt <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (col_valid)
                    begin
                        // last column of a row returns the count to zero.
                        if (col_cnt == cnt_width'(img_width - 1))
                            col_cnt <= '0;
                        else
                            col_cnt <= col_cnt + 1'b1;
                        // the first four columns only prime the reuse registers.
                        if (col_cnt >= cnt_width'(win_size - 1))
                            state <= st_emit;
                        else
                            state <= st_shift;
                    end
                st_emit:
                    if (win_ready)
                        state <= st_shift;
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_idle && col_valid)
            new_col <= col_data;
        if (state == st_shift)
        begin
            for (int c = 0; c < win_size - 2; c++)
                reuse[c] <= reuse[c + 1];
            reuse[win_size - 2] <= new_col;
        end
    end

    // column 0 is the oldest, the new column sits last.
    always_comb
    begin
        for (int c = 0; c < win_size - 1; c++)
            for (int r = 0; r < win_size; r++)
                win_data[c * win_size + r] = reuse[c][r];
        for (int r = 0; r < win_size; r++)
            win_data[(win_size - 1) * win_size + r] = new_col[r];
    end

endmodule

`default_nettype wire

//--- rtl/mac_tree.sv
`timescale 1ns/1ps
`default_nettype none

module mac_tree
(
    input  wire                                  clk,
    input  wire                                  nrst,
    input  wire                                  win_valid,
    input  wire signed [pu_pkg::data_width-1:0]  win_data [pu_pkg::win_elems],
    input  wire signed [pu_pkg::data_width-1:0]  weights [pu_pkg::win_elems],
    output logic                                 win_ready,
    output logic                                 out_valid,
    input  wire                                  out_ready,
    output logic signed [pu_pkg::acc_width-1:0]  out_sum
);
    import pu_pkg::*;

    logic                           s1_valid;
    logic                           s2_valid;
    logic                           s1_adv;
    logic                           s2_adv;
    logic signed [2*data_width-1:0] prod [win_elems];
    logic signed [acc_width-1:0]    sum_c;

    // a stage moves when it is empty or the next one moves.
    assign s2_adv    = !s2_valid || out_ready;
    assign s1_adv    = !s1_valid || s2_adv;
    assign win_ready = s1_adv;
    assign out_valid = s2_valid;

    always_comb
    begin
        sum_c = '0;
        for (int i = 0; i < win_elems; i++)
            sum_c = sum_c + acc_width'(prod[i]);
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else
        begin
            if (s1_adv)
                s1_valid <= win_valid;
            if (s2_adv)
                s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (s1_adv && win_valid)
        begin
            for (int i = 0; i < win_elems; i++)
                prod[i] <= win_data[i] * weights[i];
        end
        if (s2_adv && s1_valid)
            out_sum <= sum_c;
    end

endmodule

`default_nettype wire

//--- rtl/pu_top.sv
`timescale 1ns/1ps
`default_nettype none

module pu_top
#(
    parameter int img_width = 8
)
(
    input  wire                                  clk,
    input  wire                                  nrst,
    input  wire                                  in_valid,
    output logic                                 in_ready,
    input  wire                                  in_kind,
    input  wire pu_pkg::stream_word_u            in_word,
    output logic                                 out_valid,
    input  wire                                  out_ready,
    output logic signed [pu_pkg::acc_width-1:0]  out_sum
);
    import pu_pkg::*;

    logic                         w_wr;
    logic [4:0]                   w_idx;
    logic signed [data_width-1:0] w_data;
    logic signed [data_width-1:0] weights [win_elems];
    logic                         col_valid;
    logic                         col_ready;
    logic signed [data_width-1:0] col_data [win_size];
    logic                         win_valid;
    logic                         win_ready;
    logic signed [data_width-1:0] win_data [win_elems];

    stream_unpack u_stream_unpack (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (in_valid),
        .in_kind   (in_kind),
        .in_word   (in_word),
        .in_ready  (in_ready),
        .w_wr      (w_wr),
        .w_idx     (w_idx),
        .w_data    (w_data),
        .col_valid (col_valid),
        .col_ready (col_ready),
        .col_data  (col_data)
    );

    weight_store u_weight_store (
        .clk     (clk),
        .nrst    (nrst),
        .w_wr    (w_wr),
        .w_idx   (w_idx),
        .w_data  (w_data),
        .weights (weights)
    );

    window_ctrl #(
        .img_width (img_width)
    ) u_window_ctrl (
        .clk       (clk),
        .nrst      (nrst),
        .col_valid (col_valid),
        .col_data  (col_data),
        .col_ready (col_ready),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .win_data  (win_data)
    );

    mac_tree u_mac_tree (
        .clk       (clk),
        .nrst      (nrst),
        .win_valid (win_valid),
        .win_data  (win_data),
        .weights   (weights),
        .win_ready (win_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum)
    );

endmodule

`default_nettype wire

//--- verif/pu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pu_checker
(
    input wire                                clk,
    input wire                                nrst,
    input wire                                out_valid,
    input wire                                out_ready,
    input wire signed [pu_pkg::acc_width-1:0] out_sum
);

    // a stalled result keeps its value until it is taken.
    a_out_hold: assert property (@(posedge clk) disable iff (!nrst)
        out_valid && !out_ready |=> out_valid && $stable(out_sum))
        else $error("out_sum changed or out_valid dropped while stalled");

    a_reset_quiet: assert property (@(posedge clk) $rose(nrst) |-> !out_valid)
        else $error("out_valid high in the first cycle after reset");

endmodule

`default_nettype wire

//--- verif/pu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pu_tb;
    import pu_pkg::*;

    localparam int img_width    = 8;
    localparam int reset_cycles = 8;

    logic                        clk;
    logic                        nrst;
    logic                        in_valid;
    logic                        in_ready;
    logic                        in_kind;
    stream_word_u                in_word;
    logic                        out_valid;
    logic                        out_ready;
    logic signed [acc_width-1:0] out_sum;

    int     seed;
    int     weight_q [$];
    int     pixel_q [$];
    longint exp_q [$];
    int     row_order [$];
    int     got;
    int     limit_cycles;

    pu_top #(
        .img_width (img_width)
    ) u_pu_top (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_kind   (in_kind),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum)
    );

    bind pu_top pu_checker u_pu_checker (
        .clk       (clk),
        .nrst      (nrst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (actual != expected)
            report_failure($sformatf("FAIL at %0t ns: %s expected %0d, got %0d",
                                     $time, name, expected, actual));
    endtask

    // W and C lines carry five values, E lines one.
    task automatic read_testdata();
        int     fd;
        longint v [5];
        string  line;
        fd = $fopen("verif/pu_testdata.txt", "r");
        if (fd == 0)
            report_failure("could not open verif/pu_testdata.txt");
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d",
                              v[0], v[1], v[2], v[3], v[4]));
                case (line.getc(0))
                    "W":
                        for (int i = 0; i < win_size; i++)
                            weight_q.push_back(int'(v[i]));
                    "C":
                        for (int i = 0; i < win_size; i++)
                            pixel_q.push_back(int'(v[i]));
                    "E":
                        exp_q.push_back(v[0]);
                    default:
                        ;
                endcase
            end
            $fclose(fd);
        end
    endtask

    // rows 0 to 3 in random order and row 4 always last.
    task automatic shuffle_rows(input int ncols);
        int perm [4];
        int j;
        int t;
        for (int c = 0; c < ncols; c++)
        begin
            perm = '{0, 1, 2, 3};
            for (int i = 3; i > 0; i--)
            begin
                j = int'($unsigned($random(seed)) % (i + 1));
                t = perm[i];
                perm[i] = perm[j];
                perm[j] = t;
            end
            for (int i = 0; i < 4; i++)
                row_order.push_back(perm[i]);
            row_order.push_back(win_size - 1);
        end
    endtask

    // called on a rising edge and returns on the edge that takes the word.
    task automatic send_word(input logic kind, input stream_word_u word);
        in_valid <= 1'b1;
        in_kind  <= kind;
        in_word  <= word;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        stream_word_u word;
        int           r;
        int           quiet;
        nrst         = 1'b0;
        in_valid     = 1'b0;
        in_kind      = kind_pixel;
        in_word      = '0;
        out_ready    = 1'b0;
        seed         = 80;
        got          = 0;
        limit_cycles = 0;
        read_testdata();
        check_value("weight count", win_elems, weight_q.size());
        shuffle_rows(pixel_q.size() / win_size);
        limit_cycles = (weight_q.size() + pixel_q.size()) * 20 + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_value("in_ready", 1, longint'(in_ready));
        check_value("out_valid", 0, longint'(out_valid));
        @(posedge clk);
        for (int i = 0; i < weight_q.size(); i++)
        begin
            word = '0;
            word.wgt.idx = 5'(i);
            word.wgt.weight = 16'(weight_q[i]);
            send_word(kind_weight, word);
        end
        for (int i = 0; i < pixel_q.size(); i++)
        begin
            r = row_order[i];
            word = '0;
            word.pix.row = 3'(r);
            word.pix.pixel = 16'(pixel_q[i - i % win_size + r]);
            send_word(kind_pixel, word);
        end
        in_valid <= 1'b0;
        while (got < exp_q.size())
            @(posedge clk);
        quiet = 0;
        while (quiet < 10)
        begin
            @(negedge clk);
            quiet = out_valid ? 0 : quiet + 1;
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial
    begin
        wait (nrst == 1'b1);
        forever
        begin
            @(posedge clk);
            out_ready <= 1'($random(seed));
        end
    end

    // results are checked in order and a stalled one must not change.
    initial
    begin
        logic   held;
        longint held_sum;
        held = 1'b0;
        held_sum = 0;
        forever
        begin
            @(negedge clk);
            if (held)
            begin
                check_value("out_valid while stalled", 1, longint'(out_valid));
                check_value("out_sum while stalled", held_sum, longint'(out_sum));
            end
            if (nrst && out_valid && out_ready)
            begin
                if (got >= exp_q.size())
                    report_failure("a result arrived beyond the expected count");
                else
                begin
                    check_value("out_sum", exp_q[got], longint'(out_sum));
                    got++;
                end
            end
            held = nrst && out_valid && !out_ready;
            held_sum = longint'(out_sum);
        end
    end

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        report_failure($sformatf("watchdog expired after %0d cycles before all results arrived",
                                 limit_cycles));
    end

endmodule

`default_nettype wire

//--- verif/pu_testdata.txt
# W: one kernel column, weights of rows 0 to 4. C: one image column, pixels of rows 0 to 4.
# E: expected sum of one window, in output order. All values are signed decimal.
W 32767 1 2 -3 1
W 32767 -2 1 0 5
W 32767 3 -1 2 0
W 32767 0 4 1 -2
W 32767 2 0 -1 1
# first image row
C 10 1 2 3 4
C -5 0 -1 2 1
C 7 3 0 -2 5
C 0 -4 6 1 -3
C 2 2 2 2 2
C -8 5 -3 0 1
C 4 -1 1 -1 1
C 1 6 -2 3 0
E 458782
E -131055
E 163842
E -32729
# second image row, sums beyond 32 bits
C 32767 1 0 0 0
C 32767 0 1 0 0
C 32767 0 0 1 0
C 32767 0 0 0 1
C 32767 1 1 1 1
C -32768 2 0 -1 3
C 32767 -7 4 0 0
C -32768 0 -5 2 1
E 5368381449
E 3220996113
E 3220996085
E 1073610779

//--- list.f
common/pu_pkg.sv
rtl/stream_unpack.sv
rtl/weight_store.sv
pu_control/window_ctrl.sv
rtl/mac_tree.sv
rtl/pu_top.sv
verif/pu_checker.sv
verif/pu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module pu_tb -o pu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/pu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
